/* vlog.f */
+incdir+source
source/dwconv_pkg.sv
source/dwconv_ctrl.sv
source/channel_mac.sv
source/requant_relu.sv
source/result_fifo.sv
source/dwconv_top.sv
testbench/dwconv_checker.sv
testbench/dwconv_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build with Verilator, run, then decide on the log
set -o pipefail
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module dwconv_tb \
  -f vlog.f -o dwconv_sim \
  && ./obj_dir/dwconv_sim 2>&1 | tee sim.log \
  || { echo "build or simulation failed"; exit 1; }

! grep -q -e "TESTS FAILED" -e "%Error" sim.log \
  && grep -q "TESTS PASSED" sim.log \
  && echo "simulation passed" \
  || { echo "simulation failed, see sim.log"; exit 1; }

/* testbench/dwconv_tb.sv */
`timescale 1ns/10ps
`default_nettype none

`include "dwconv_consts.svh"

module dwconv_tb;

  localparam int N_RAND  = 200;
  localparam int N_STALL = 8;
  localparam int N_GAP   = 60;
  localparam int N_TOTAL = 3 + N_RAND + N_STALL + N_GAP;
  localparam int TIMEOUT = 40 * N_TOTAL + 200;

  // kernels, row-major taps, and biases of the eight channels
  localparam int W_TAB [`DW_CHANNELS][`DW_TAPS] = '{
    '{-19, -51, -19,  10,  -5,  -8,  19,  23,  19},
    '{ 13,  69,   0,  -8, -74,   4,  -6,   7,  -5},
    '{ -5,  -9,  -8,   3,  -2,  -7,  17,  14,  -3},
    '{ 31,   3, -35,  16,  -6, -31,   4,   8,  11},
    '{  2,   1,  19,   8,  -8,   7,  -6,  -4,  -5},
    '{  4,  66, -37,   9,  45,  -5, -20, -36,  -5},
    '{-35,  31,  50,  -1,  27,  13,   2, -29, -43},
    '{  6, -31, -30,  -6, -13, -12,   4,  34,  24}
  };
  localparam int B_TAB [`DW_CHANNELS] = '{41, 19, -7, 46, -22, 27, 14, 34};

  logic                  clk;
  logic                  rstn;
  logic                  in_req;
  dwconv_pkg::window_t   in_data;
  logic                  in_ack;
  logic                  out_req;
  dwconv_pkg::out_word_t out_data;
  logic                  out_ack;

  dwconv_pkg::window_t   win_q [$];
  dwconv_pkg::out_word_t exp_q [$];

  int in_max_gap = 0;
  int ack_max_delay = 0;
  bit ack_hold = 0;
  int accepted = 0;
  int words_checked = 0;
  int word_errs = 0;
  int act_errs = 0;
  int other_errs = 0;
  int cycles = 0;

  dwconv_top u_dut (
    .clk      (clk),
    .rstn     (rstn),
    .in_req   (in_req),
    .in_data  (in_data),
    .in_ack   (in_ack),
    .out_req  (out_req),
    .out_data (out_data),
    .out_ack  (out_ack)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // weighted sum plus bias, then shift and clamp to [0, 6.0]
  function automatic dwconv_pkg::out_word_t ref_conv(input dwconv_pkg::window_t w);
    dwconv_pkg::out_word_t res;
    int s;
    int q;
    res = '0;
    for (int c = 0; c < `DW_CHANNELS; c++) begin
      s = B_TAB[c];
      for (int t = 0; t < `DW_TAPS; t++) begin
        s += int'($signed(w[(c*`DW_TAPS+t)*`DW_ACT_W +: `DW_ACT_W])) * W_TAB[c][t];
      end
      q = (s < 0) ? 0 : (s >>> `DW_FRAC_SHIFT);
      if (q > `DW_RELU_CAP) begin
        q = `DW_RELU_CAP;
      end
      res[c*`DW_OUT_W +: `DW_OUT_W] = q[`DW_OUT_W-1:0];
    end
    return res;
  endfunction

  function automatic dwconv_pkg::window_t rand_window();
    dwconv_pkg::window_t w;
    for (int i = 0; i < $bits(w) / 32; i++) begin
      w[i*32 +: 32] = $urandom();
    end
    return w;
  endfunction

  task automatic check_act(input int ch, input dwconv_pkg::out_act_t got,
                           input dwconv_pkg::out_act_t exp);
    if (got !== exp) begin
      act_errs++;
      $display("FAILED out_data channel %0d: got %h, expected %h", ch, got, exp);
    end
  endtask

  task automatic check_word(input dwconv_pkg::out_word_t got,
                            input dwconv_pkg::out_word_t exp);
    if (got !== exp) begin
      word_errs++;
      $display("FAILED out_data: got %h, expected %h", got, exp);
      for (int c = 0; c < `DW_CHANNELS; c++) begin
        check_act(c, got[c*`DW_OUT_W +: `DW_OUT_W], exp[c*`DW_OUT_W +: `DW_OUT_W]);
      end
    end
  endtask

  task automatic wait_drain();
    while (win_q.size() != 0 || exp_q.size() != 0) begin
      @(posedge clk);
    end
    repeat (4) @(posedge clk);
  endtask

  // one four-phase input transfer per queued window
  initial begin
    dwconv_pkg::window_t w;
    in_req  <= 1'b0;
    in_data <= '0;
    forever begin
      @(posedge clk);
      if (win_q.size() != 0) begin
        w = win_q.pop_front();
        exp_q.push_back(ref_conv(w));
        repeat ($urandom_range(in_max_gap, 0)) @(posedge clk);
        in_data <= w;
        in_req  <= 1'b1;
        do @(posedge clk); while (!in_ack);
        accepted++;
        in_req <= 1'b0;
        do @(posedge clk); while (in_ack);
      end
    end
  end

  // output side acknowledge
  initial begin
    out_ack <= 1'b0;
    forever begin
      @(posedge clk);
      if (out_req && !out_ack && !ack_hold) begin
        repeat ($urandom_range(ack_max_delay, 0)) @(posedge clk);
        out_ack <= 1'b1;
        do @(posedge clk); while (out_req);
        out_ack <= 1'b0;
      end
    end
  end

  // a word is taken on the edge where req and ack are both high
  always @(posedge clk) begin
    if (rstn && out_req && out_ack) begin
      if (exp_q.size() == 0) begin
        other_errs++;
        $display("output word arrived with no window outstanding");
      end else begin
        check_word(out_data, exp_q.pop_front());
        words_checked++;
      end
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT) begin
      $display("timeout: results still missing after %0d cycles", TIMEOUT);
      $display("TESTS FAILED");
      $finish;
    end
  end

  initial begin
    int base;
    void'($urandom(32'h76c02c8f));
    rstn <= 1'b0;
    repeat (5) @(posedge clk);
    rstn <= 1'b1;
    @(posedge clk);

    // zero window followed by the extremes for both clamps
    win_q.push_back('0);
    win_q.push_back({(`DW_CHANNELS*`DW_TAPS){8'h7f}});
    win_q.push_back({(`DW_CHANNELS*`DW_TAPS){8'h80}});
    wait_drain();

    repeat (N_RAND) win_q.push_back(rand_window());
    wait_drain();

    // with the receiver stalled the credits must stop the input side
    ack_hold <= 1'b1;
    base = accepted;
    repeat (N_STALL) win_q.push_back(rand_window());
    repeat (100) @(posedge clk);
    if (accepted - base != `DW_FIFO_DEPTH) begin
      other_errs++;
      $display("FAILED accepted windows: got %h, expected %h", accepted - base,
               `DW_FIFO_DEPTH);
    end
    ack_hold <= 1'b0;
    wait_drain();

    in_max_gap    <= 6;
    ack_max_delay <= 6;
    repeat (N_GAP) win_q.push_back(rand_window());
    wait_drain();

    // every window is answered, so no further word may be offered
    if (out_req) begin
      other_errs++;
      $display("a result word was still offered after all windows were answered");
    end
    $display("summary: %0d words, %0d word errors, %0d channel errors, %0d other errors",
             words_checked, word_errs, act_errs, other_errs);
    if (word_errs + act_errs + other_errs == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* testbench/dwconv_checker.sv */
`timescale 1ns/10ps
`default_nettype none

module dwconv_checker (
  input logic                  clk,
  input logic                  rstn,
  input logic                  in_req,
  input logic                  in_ack,
  input logic                  out_req,
  input logic                  out_ack,
  input dwconv_pkg::out_word_t out_data
);

  // ack only answers a pending request
  a_ack_needs_req: assert property (@(posedge clk) disable iff (!rstn)
    $rose(in_ack) |-> $past(in_req))
    else $error("in_ack rose without in_req");

  a_req_holds: assert property (@(posedge clk) disable iff (!rstn)
    out_req && !out_ack |=> out_req)
    else $error("out_req dropped before out_ack");

  // head of the buffer must not move under a request
  a_data_stable: assert property (@(posedge clk) disable iff (!rstn)
    out_req |=> !out_req || $stable(out_data))
    else $error("out_data changed while out_req was high");

  a_reset_low: assert property (@(posedge clk)
    !rstn |=> !in_ack && !out_req)
    else $error("handshake outputs high after reset");

endmodule

bind dwconv_top dwconv_checker u_checker (
  .clk      (clk),
  .rstn     (rstn),
  .in_req   (in_req),
  .in_ack   (in_ack),
  .out_req  (out_req),
  .out_ack  (out_ack),
  .out_data (out_data)
);

`default_nettype wire

/* source/dwconv_top.sv */
`timescale 1ns/10ps
`default_nettype none

`include "dwconv_consts.svh"

module dwconv_top (
  input  logic                  clk,
  input  logic                  rstn,
  input  logic                  in_req,
  input  dwconv_pkg::window_t   in_data,
  output logic                  in_ack,
  output logic                  out_req,
  output dwconv_pkg::out_word_t out_data,
  input  logic                  out_ack
);

  localparam int WIN_W = `DW_TAPS * `DW_ACT_W;

  logic capture;
  logic fifo_push;
  logic fifo_pop;
  logic fifo_empty;

  dwconv_pkg::acc_t [`DW_CHANNELS-1:0] sums;
  dwconv_pkg::out_word_t               result_word;

  dwconv_ctrl u_ctrl (
    .clk        (clk),
    .rstn       (rstn),
    .in_req     (in_req),
    .out_ack    (out_ack),
    .fifo_empty (fifo_empty),
    .in_ack     (in_ack),
    .out_req    (out_req),
    .capture    (capture),
    .fifo_push  (fifo_push),
    .fifo_pop   (fifo_pop)
  );

  // one MAC per channel, each with its own kernel
  for (genvar i = 0; i < `DW_CHANNELS; i++) begin : g_ch
    channel_mac #(
      .ch_index (i)
    ) u_mac (
      .clk     (clk),
      .rstn    (rstn),
      .capture (capture),
      .window  (in_data[i*WIN_W +: WIN_W]),
      .sum     (sums[i])
    );
  end

  requant_relu u_requant (
    .sums (sums),
    .word (result_word)
  );

  // out_data is the buffer head
  result_fifo u_fifo (
    .clk   (clk),
    .rstn  (rstn),
    .push  (fifo_push),
    .pop   (fifo_pop),
    .din   (result_word),
    .dout  (out_data),
    .empty (fifo_empty)
  );

endmodule

`default_nettype wire

/* source/result_fifo.sv */
`timescale 1ns/10ps
`default_nettype none

`include "dwconv_consts.svh"

module result_fifo (
  input  logic                  clk,
  input  logic                  rstn,
  input  logic                  push,
  input  logic                  pop,
  input  dwconv_pkg::out_word_t din,
  output dwconv_pkg::out_word_t dout,
  output logic                  empty
);

  localparam int AW = $clog2(`DW_FIFO_DEPTH);

  dwconv_pkg::out_word_t mem [`DW_FIFO_DEPTH];

  // extra msb tells full from empty
  logic [AW:0] wr_ptr;
  logic [AW:0] rd_ptr;

  assign empty = (wr_ptr == rd_ptr);
  assign dout  = mem[rd_ptr[AW-1:0]];

  // storage
  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr[AW-1:0]] <= din;
    end
  end

  always_ff @(posedge clk) begin
    if (!rstn) begin
      wr_ptr <= '0;
    end else if (push) begin
      wr_ptr <= wr_ptr + 1'b1;
    end
  end

  // a pop on an empty buffer is ignored
  always_ff @(posedge clk) begin
    if (!rstn) begin
      rd_ptr <= '0;
    end else if (pop && !empty) begin
      rd_ptr <= rd_ptr + 1'b1;
    end
  end

endmodule

`default_nettype wire

/* source/requant_relu.sv */
`timescale 1ns/10ps
`default_nettype none

`include "dwconv_consts.svh"

module requant_relu (
  input  dwconv_pkg::acc_t [`DW_CHANNELS-1:0] sums,
  output dwconv_pkg::out_word_t               word
);

  // per-channel bias, same scale as the sums
  localparam int BIAS [`DW_CHANNELS] = '{41, 19, -7, 46, -22, 27, 14, 34};

  // negative goes to 0, otherwise shift and cap at 6.0
  function automatic dwconv_pkg::out_act_t relu6(input dwconv_pkg::acc_t s);
    dwconv_pkg::acc_t shifted;
    dwconv_pkg::out_act_t res;
    shifted = s >>> `DW_FRAC_SHIFT;
    if (s < 0) begin
      res = '0;
    end else if (shifted > dwconv_pkg::acc_t'(`DW_RELU_CAP)) begin
      res = dwconv_pkg::out_act_t'(`DW_RELU_CAP);
    end else begin
      res = shifted[`DW_OUT_W-1:0];
    end
    return res;
  endfunction

  dwconv_pkg::acc_t biased [`DW_CHANNELS];

  always_comb begin
    for (int c = 0; c < `DW_CHANNELS; c++) begin
      biased[c] = sums[c] + BIAS[c];
      word[c*`DW_OUT_W +: `DW_OUT_W] = relu6(biased[c]);
    end
  end

endmodule

`default_nettype wire

/* source/channel_mac.sv */
`timescale 1ns/10ps
`default_nettype none

`include "dwconv_consts.svh"

module channel_mac #(
  parameter int ch_index = 0
) (
  input  logic                             clk,
  input  logic                             rstn,
  input  logic                             capture,
  input  logic [`DW_TAPS*`DW_ACT_W-1:0]    window,
  output dwconv_pkg::acc_t                 sum
);

  // fixed kernels, taps in row-major order (r0c0 .. r2c2)
  // channel 1 has no upper-right tap
  localparam int KERNEL [`DW_CHANNELS][`DW_TAPS] = '{
    '{-19, -51, -19,  10,  -5,  -8,  19,  23,  19},
    '{ 13,  69,   0,  -8, -74,   4,  -6,   7,  -5},
    '{ -5,  -9,  -8,   3,  -2,  -7,  17,  14,  -3},
    '{ 31,   3, -35,  16,  -6, -31,   4,   8,  11},
    '{  2,   1,  19,   8,  -8,   7,  -6,  -4,  -5},
    '{  4,  66, -37,   9,  45,  -5, -20, -36,  -5},
    '{-35,  31,  50,  -1,  27,  13,   2, -29, -43},
    '{  6, -31, -30,  -6, -13, -12,   4,  34,  24}
  };

  logic [`DW_TAPS*`DW_ACT_W-1:0] win_q;

  dwconv_pkg::act_t pix  [`DW_TAPS];
  dwconv_pkg::acc_t prod [`DW_TAPS];

  // adder tree, 9 -> 5 -> 3 -> 2 -> 1
  dwconv_pkg::acc_t s0 [5];
  dwconv_pkg::acc_t s1 [3];
  dwconv_pkg::acc_t s2 [2];
  dwconv_pkg::acc_t s3;

  // window held for the multiplies
  always_ff @(posedge clk) begin
    if (!rstn) begin
      win_q <= '0;
    end else if (capture) begin
      win_q <= window;
    end
  end

  always_comb begin
    for (int t = 0; t < `DW_TAPS; t++) begin
      pix[t]  = win_q[t*`DW_ACT_W +: `DW_ACT_W];
      prod[t] = pix[t] * KERNEL[ch_index][t];
    end
  end

  // pipeline runs every cycle, valid is tracked by the control module
  always_ff @(posedge clk) begin
    for (int k = 0; k < 4; k++) begin
      s0[k] <= prod[2*k] + prod[2*k+1];
    end
    s0[4] <= prod[8];

    s1[0] <= s0[0] + s0[1];
    s1[1] <= s0[2] + s0[3];
    s1[2] <= s0[4];

    s2[0] <= s1[0] + s1[1];
    s2[1] <= s1[2];

    s3 <= s2[0] + s2[1];
  end

  assign sum = s3;

endmodule

`default_nettype wire

/* source/dwconv_ctrl.sv */
`timescale 1ns/10ps
`default_nettype none

`include "dwconv_consts.svh"

module dwconv_ctrl (
  input  logic clk,
  input  logic rstn,
  input  logic in_req,
  input  logic out_ack,
  input  logic fifo_empty,
  output logic in_ack,
  output logic out_req,
  output logic capture,
  output logic fifo_push,
  output logic fifo_pop
);

  localparam int CW = $clog2(`DW_FIFO_DEPTH + 1);

  dwconv_pkg::in_state_e  in_state;
  dwconv_pkg::out_state_e out_state;

  // windows in the pipeline plus entries held in the buffer
  logic [CW-1:0] credit_cnt;
  logic          credit_ok;

  // one bit per pipeline stage, tracks valid windows
  logic [`DW_PIPE_LAT-1:0] pipe_v;

  assign credit_ok = (credit_cnt < CW'(`DW_FIFO_DEPTH));

  // accept only a fresh request, and only with a free buffer slot
  assign capture = (in_state == dwconv_pkg::in_idle) && in_req && credit_ok;

  assign in_ack = (in_state == dwconv_pkg::in_ack_hi);

  // input handshake
  always_ff @(posedge clk) begin
    if (!rstn) begin
      in_state <= dwconv_pkg::in_idle;
    end else begin
      case (in_state)
        dwconv_pkg::in_idle: begin
          if (capture) begin
            in_state <= dwconv_pkg::in_ack_hi;
          end
        end
        dwconv_pkg::in_ack_hi: begin
          // sender has dropped req, release ack
          if (!in_req) begin
            in_state <= dwconv_pkg::in_idle;
          end
        end
        default: in_state <= dwconv_pkg::in_idle;
      endcase
    end
  end

  // valid travels alongside the window data
  always_ff @(posedge clk) begin
    if (!rstn) begin
      pipe_v <= '0;
    end else begin
      pipe_v <= {pipe_v[`DW_PIPE_LAT-2:0], capture};
    end
  end

  assign fifo_push = pipe_v[`DW_PIPE_LAT-1];

  // head leaves the buffer when the receiver acknowledges it
  assign fifo_pop = (out_state == dwconv_pkg::out_req_hi) && out_ack;

  assign out_req = (out_state == dwconv_pkg::out_req_hi);

  // output handshake
  always_ff @(posedge clk) begin
    if (!rstn) begin
      out_state <= dwconv_pkg::out_idle;
    end else begin
      case (out_state)
        dwconv_pkg::out_idle: begin
          if (!fifo_empty && !out_ack) begin
            out_state <= dwconv_pkg::out_req_hi;
          end
        end
        dwconv_pkg::out_req_hi: begin
          if (out_ack) begin
            out_state <= dwconv_pkg::out_wait_low;
          end
        end
        dwconv_pkg::out_wait_low: begin
          // receiver must release ack before the next request
          if (!out_ack) begin
            out_state <= dwconv_pkg::out_idle;
          end
        end
        default: out_state <= dwconv_pkg::out_idle;
      endcase
    end
  end

  // credit count, up on accept and down on pop
  always_ff @(posedge clk) begin
    if (!rstn) begin
      credit_cnt <= '0;
    end else begin
      case ({capture, fifo_pop})
        2'b10:   credit_cnt <= credit_cnt + CW'(1);
        2'b01:   credit_cnt <= credit_cnt - CW'(1);
        default: credit_cnt <= credit_cnt;
      endcase
    end
  end

endmodule

`default_nettype wire

/* source/dwconv_pkg.sv */
`default_nettype none

`include "dwconv_consts.svh"

package dwconv_pkg;

  // one signed input pixel
  typedef logic signed [`DW_ACT_W-1:0] act_t;

  // all windows of all channels, channel 0 in the low bits
  typedef logic [`DW_CHANNELS*`DW_TAPS*`DW_ACT_W-1:0] window_t;

  // per-channel sum
  typedef logic signed [`DW_ACC_W-1:0] acc_t;

  // one requantized output
  typedef logic [`DW_OUT_W-1:0] out_act_t;

  // packed output word, channel 0 in the low byte
  typedef logic [`DW_CHANNELS*`DW_OUT_W-1:0] out_word_t;

  // input side four-phase handshake
  typedef enum logic {
    in_idle,
    in_ack_hi
  } in_state_e;

  // output side four-phase handshake
  typedef enum logic [1:0] {
    out_idle,
    out_req_hi,
    out_wait_low
  } out_state_e;

endpackage

`default_nettype wire

/* source/dwconv_consts.svh */
`ifndef DWCONV_CONSTS_SVH
`define DWCONV_CONSTS_SVH

// channel and window geometry
`define DW_CHANNELS 8
`define DW_TAPS 9

// pixel and accumulator widths
`define DW_ACT_W 8
`define DW_ACC_W 32

// output width, one unsigned byte per channel
`define DW_OUT_W 8

// requantization, four fraction bits in the output format
`define DW_FRAC_SHIFT 4
// 6.0 with four fraction bits
`define DW_RELU_CAP 96

// result buffer entries
`define DW_FIFO_DEPTH 4

// capture register plus four adder tree stages
`define DW_PIPE_LAT 5

`endif
